/* include/tlb_macros.svh */
// size macros for the MMU: slice count, TLB geometry and page table depth
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// number of TLB slices behind the steer
// the top log2 bits of the request ID pick the slice
`define MMU_PORTS 4

// sets per slice, indexed by the low VPN bits
`define TLB_SETS 16

// ways per set, FIFO replacement
`define TLB_WAYS 2

// page table RAM entries, direct mapped on the low VPN bits
`define PT_DEPTH 64

`endif

/* hdl/tlb_pkg.sv */
// MMU package with request, response, walk and page table write structs and FSM enums
package tlb_pkg;

    typedef struct packed {
        logic       mode;   // 0 = bare, no translation
        logic [8:0] asid;
    } satp_t;

    typedef struct packed {
        logic [7:0]  id;    // zero never issued
        logic [31:0] vaddr;
        satp_t       satp;
    } xlat_req_t;

    typedef struct packed {
        logic [7:0]  id;
        logic [7:0]  perm;  // zero is a page fault
        logic [31:0] paddr;
    } xlat_resp_t;

    // also serves as the tag of a TLB entry and of a page table entry
    typedef struct packed {
        logic [19:0] vpn;
        logic [8:0]  asid;
    } walk_req_t;

    typedef struct packed {
        logic [19:0] ppn;
        logic [7:0]  perm;
    } walk_resp_t;

    typedef struct packed {
        walk_req_t  tag;
        walk_resp_t data;
    } pt_write_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,     // tags being compared
        WAIT_WALK,  // miss outstanding
        FILL        // walk result going out
    } slice_state_e;

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_DROP
    } hs_state_e;

endpackage

/* hdl/req_steer.sv */
// request steering from the single input port to the TLB slices
`include "tlb_macros.svh"

module req_steer import tlb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  xlat_req_t             req,
    input  logic                  req_valid,
    output logic                  req_ready,
    output xlat_req_t             slice_req [`MMU_PORTS],
    output logic [`MMU_PORTS-1:0] slice_valid,
    input  logic [`MMU_PORTS-1:0] slice_ready
);
    localparam int SEL_W = $clog2(`MMU_PORTS);

    logic [SEL_W-1:0] sel;

    assign sel       = req.id[7 -: SEL_W]; // top ID bits
    assign req_ready = slice_ready[sel];   // busy slice stalls the input

    always_comb begin
        slice_valid      = '0;
        slice_valid[sel] = req_valid;
        for (int i = 0; i < `MMU_PORTS; i++) begin
            slice_req[i] = req; // payload goes to every slice
        end
    end

endmodule

/* hdl/tlb_slice.sv */
// set-associative ASID-tagged TLB slice with bare bypass, FIFO refill, flush and one miss
`include "tlb_macros.svh"

module tlb_slice import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  xlat_req_t  req,
    input  logic       req_valid,
    output logic       req_ready,
    output xlat_resp_t resp,
    output logic       resp_valid,
    output logic       miss_valid,
    output walk_req_t  miss_req,
    input  logic       fill_valid,
    input  walk_resp_t fill_resp,
    input  logic       flush_valid,
    input  logic [8:0] flush_asid,
    input  logic [8:0] flush_mask
);
    localparam int SET_W = $clog2(`TLB_SETS);
    localparam int WAY_W = $clog2(`TLB_WAYS);

    walk_req_t            tlb_tag [`TLB_SETS][`TLB_WAYS];
    walk_resp_t           tlb_dat [`TLB_SETS][`TLB_WAYS];
    logic [`TLB_WAYS-1:0] tlb_vld [`TLB_SETS];
    logic [WAY_W-1:0]     tlb_ptr [`TLB_SETS]; // next way to replace

    slice_state_e         state;
    logic                 accept;
    logic [SET_W-1:0]     rd_set;
    xlat_req_t            b_req;   // request in compare stage
    walk_req_t            set_tag [`TLB_WAYS];
    walk_resp_t           set_dat [`TLB_WAYS];
    logic [`TLB_WAYS-1:0] set_vld;
    logic [WAY_W-1:0]     set_ptr;
    walk_req_t            look_tag;
    logic [`TLB_WAYS-1:0] set_hit;
    logic [WAY_W-1:0]     hit_way;
    logic                 bare;
    logic                 hit;
    xlat_req_t            mis_req;
    logic [WAY_W-1:0]     mis_ptr;
    logic [SET_W-1:0]     mis_set;
    logic                 fill_write;

    function automatic logic flush_match(input logic [8:0] asid);
        return ((asid ^ flush_asid) & ~flush_mask) == 9'd0;
    endfunction

    assign accept     = req_valid && req_ready;
    assign rd_set     = req.vaddr[12 +: SET_W];
    assign mis_set    = mis_req.vaddr[12 +: SET_W];
    assign look_tag   = '{vpn: b_req.vaddr[31:12], asid: b_req.satp.asid};
    assign bare       = ~b_req.satp.mode;
    assign hit        = bare || (|set_hit);
    assign fill_write = (state == WAIT_WALK) && fill_valid && (|fill_resp.perm); // faults not cached
    assign miss_valid = (state == WAIT_WALK);
    assign miss_req   = '{vpn: mis_req.vaddr[31:12], asid: mis_req.satp.asid};

    always_comb begin
        case (state)
            IDLE, FILL: req_ready = 1'b1;
            LOOKUP:     req_ready = hit; // a miss blocks the next request
            default:    req_ready = 1'b0;
        endcase
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `TLB_WAYS; w++) begin
            set_hit[w] = set_vld[w] && (set_tag[w] == look_tag);
        end
        for (int w = `TLB_WAYS - 1; w >= 0; w--) begin
            if (set_hit[w]) hit_way = WAY_W'(w); // lowest way wins
        end
    end

    // set snapshot taken on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            b_req   <= req;
            set_tag <= tlb_tag[rd_set];
            set_dat <= tlb_dat[rd_set];
            set_vld <= tlb_vld[rd_set];
            set_ptr <= tlb_ptr[rd_set];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: if (accept) state <= LOOKUP;
                LOOKUP: begin
                    if (!hit) begin
                        state <= WAIT_WALK;
                    end else begin
                        resp_valid <= 1'b1;
                        if (!accept) state <= IDLE;
                    end
                end
                WAIT_WALK: begin
                    if (fill_valid) begin
                        state      <= FILL;
                        resp_valid <= 1'b1; // translation or fault
                    end
                end
                FILL:    state <= accept ? LOOKUP : IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            if (hit) begin
                resp.id <= b_req.id;
                if (bare) begin
                    resp.perm  <= 8'hff;
                    resp.paddr <= b_req.vaddr;
                end else begin
                    resp.perm  <= set_dat[hit_way].perm;
                    resp.paddr <= {set_dat[hit_way].ppn, b_req.vaddr[11:0]};
                end
            end else begin
                mis_req <= b_req;
                mis_ptr <= set_ptr;
            end
        end else if (state == WAIT_WALK && fill_valid) begin
            resp.id    <= mis_req.id;
            resp.perm  <= fill_resp.perm;
            resp.paddr <= {fill_resp.ppn, mis_req.vaddr[11:0]};
        end
    end

    // valid bits and FIFO pointers, the fill overrides a flush of its own way
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `TLB_SETS; s++) begin
                tlb_vld[s] <= '0;
                tlb_ptr[s] <= '0;
            end
        end else begin
            if (flush_valid) begin
                for (int s = 0; s < `TLB_SETS; s++) begin
                    for (int w = 0; w < `TLB_WAYS; w++) begin
                        if (flush_match(tlb_tag[s][w].asid)) tlb_vld[s][w] <= 1'b0;
                    end
                end
            end
            if (fill_write) begin
                tlb_vld[mis_set][mis_ptr] <= 1'b1;
                tlb_ptr[mis_set]          <= mis_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_write) begin
            tlb_tag[mis_set][mis_ptr] <= miss_req;
            tlb_dat[mis_set][mis_ptr] <= fill_resp;
        end
    end

endmodule

/* hdl/miss_arbiter.sv */
// round-robin miss arbiter and four-phase req/ack master toward the page walker
`include "tlb_macros.svh"

module miss_arbiter import tlb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`MMU_PORTS-1:0] miss_valid,
    input  walk_req_t             miss_req [`MMU_PORTS],
    output logic [`MMU_PORTS-1:0] fill_valid,
    output walk_resp_t            fill_resp,
    output logic                  walk_req,
    output walk_req_t             walk_addr,
    input  logic                  walk_ack,
    input  walk_resp_t            walk_data
);
    localparam int SEL_W = $clog2(`MMU_PORTS);

    hs_state_e        state;
    logic [SEL_W-1:0] last;  // previous winner
    logic [SEL_W-1:0] gnt;   // slice being served
    logic [SEL_W-1:0] pick;
    logic [SEL_W-1:0] idx;
    logic             found;

    // search starts at the slice after the last winner
    always_comb begin
        pick  = last;
        found = 1'b0;
        idx   = last;
        for (int k = 1; k <= `MMU_PORTS; k++) begin
            idx = last + SEL_W'(k);
            if (!found && miss_valid[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    assign walk_req = (state == HS_REQ);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= HS_IDLE;
            last       <= '1; // slice 0 first
            fill_valid <= '0;
        end else begin
            fill_valid <= '0;
            case (state)
                HS_IDLE: if (found) state <= HS_REQ;
                HS_REQ: begin
                    if (walk_ack) begin
                        fill_valid[gnt] <= 1'b1; // one-cycle pulse
                        last            <= gnt;
                        state           <= HS_DROP;
                    end
                end
                HS_DROP: if (!walk_ack) state <= HS_IDLE;
                default: state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == HS_IDLE && found) begin
            gnt       <= pick;
            walk_addr <= miss_req[pick]; // held for the whole handshake
        end
        if (state == HS_REQ && walk_ack) fill_resp <= walk_data;
    end

endmodule

/* hdl/page_walker.sv */
// programmable direct-mapped page table RAM and four-phase walk slave
`include "tlb_macros.svh"

module page_walker import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       walk_req,
    input  walk_req_t  walk_addr,
    output logic       walk_ack,
    output walk_resp_t walk_data,
    input  logic       pt_wr_valid,
    input  pt_write_t  pt_wr
);
    localparam int IDX_W = $clog2(`PT_DEPTH);

    walk_req_t        pt_tag  [`PT_DEPTH];
    logic [19:0]      pt_ppn  [`PT_DEPTH];
    logic [7:0]       pt_perm [`PT_DEPTH]; // zero = unmapped
    hs_state_e        state;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    walk_req_t        rd_tag;
    walk_resp_t       rd_dat;

    assign wr_idx = pt_wr.tag.vpn[IDX_W-1:0];
    assign rd_idx = walk_addr.vpn[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PT_DEPTH; i++) begin
                pt_perm[i] <= '0;
            end
        end else if (pt_wr_valid) begin
            pt_perm[wr_idx] <= pt_wr.data.perm;
        end
    end

    always_ff @(posedge clk) begin
        if (pt_wr_valid) begin
            pt_tag[wr_idx] <= pt_wr.tag;
            pt_ppn[wr_idx] <= pt_wr.data.ppn;
        end
        if (state == HS_IDLE && walk_req) begin // registered RAM read
            rd_tag      <= pt_tag[rd_idx];
            rd_dat.ppn  <= pt_ppn[rd_idx];
            rd_dat.perm <= pt_perm[rd_idx];
        end
        if (state == HS_REQ) begin
            walk_data <= (rd_tag == walk_addr) ? rd_dat : '0; // tag miss is a fault
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= HS_IDLE;
            walk_ack <= 1'b0;
        end else begin
            case (state)
                HS_IDLE: if (walk_req) state <= HS_REQ;
                HS_REQ: begin
                    walk_ack <= 1'b1;
                    state    <= HS_DROP;
                end
                HS_DROP: begin
                    if (!walk_req) begin // master has latched the data
                        walk_ack <= 1'b0;
                        state    <= HS_IDLE;
                    end
                end
                default: state <= HS_IDLE;
            endcase
        end
    end

endmodule

/* hdl/mmu_top.sv */
// MMU top level with request steer, TLB slices, miss arbiter and page walker
`include "tlb_macros.svh"

module mmu_top import tlb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  xlat_req_t             req,
    input  logic                  req_valid,
    output logic                  req_ready,
    output xlat_resp_t            resp [`MMU_PORTS],
    output logic [`MMU_PORTS-1:0] resp_valid,
    input  logic                  flush_valid,
    input  logic [8:0]            flush_asid,
    input  logic [8:0]            flush_mask,
    input  logic                  pt_wr_valid,
    input  pt_write_t             pt_wr
);
    xlat_req_t             slice_req [`MMU_PORTS];
    logic [`MMU_PORTS-1:0] slice_valid;
    logic [`MMU_PORTS-1:0] slice_ready;
    logic [`MMU_PORTS-1:0] miss_valid;
    walk_req_t             miss_req [`MMU_PORTS];
    logic [`MMU_PORTS-1:0] fill_valid;
    walk_resp_t            fill_resp; // shared, qualified per slice by fill_valid
    logic                  walk_req;
    walk_req_t             walk_addr;
    logic                  walk_ack;
    walk_resp_t            walk_data;

    req_steer req_steer_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .slice_req   (slice_req),
        .slice_valid (slice_valid),
        .slice_ready (slice_ready)
    );

    for (genvar i = 0; i < `MMU_PORTS; i++) begin : g_slice
        tlb_slice tlb_slice_inst (
            .clk         (clk),
            .rst         (rst),
            .req         (slice_req[i]),
            .req_valid   (slice_valid[i]),
            .req_ready   (slice_ready[i]),
            .resp        (resp[i]),
            .resp_valid  (resp_valid[i]),
            .miss_valid  (miss_valid[i]),
            .miss_req    (miss_req[i]),
            .fill_valid  (fill_valid[i]),
            .fill_resp   (fill_resp),
            .flush_valid (flush_valid),
            .flush_asid  (flush_asid),
            .flush_mask  (flush_mask)
        );
    end

    miss_arbiter miss_arbiter_inst (
        .clk        (clk),
        .rst        (rst),
        .miss_valid (miss_valid),
        .miss_req   (miss_req),
        .fill_valid (fill_valid),
        .fill_resp  (fill_resp),
        .walk_req   (walk_req),
        .walk_addr  (walk_addr),
        .walk_ack   (walk_ack),
        .walk_data  (walk_data)
    );

    page_walker page_walker_inst (
        .clk         (clk),
        .rst         (rst),
        .walk_req    (walk_req),
        .walk_addr   (walk_addr),
        .walk_ack    (walk_ack),
        .walk_data   (walk_data),
        .pt_wr_valid (pt_wr_valid),
        .pt_wr       (pt_wr)
    );

endmodule

/* bench/mmu_assert.sv */
// walker handshake and response ID assertions for the MMU, bound into mmu_top
`include "tlb_macros.svh"

module mmu_assert import tlb_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  walk_req,
    input logic                  walk_ack,
    input xlat_resp_t            resp [`MMU_PORTS],
    input logic [`MMU_PORTS-1:0] resp_valid
);

    // request held until the walker answers
    assert property (@(posedge clk) disable iff (rst) walk_req && !walk_ack |=> walk_req)
        else $error("walk_req dropped before walk_ack");

    // ack released only once the request is gone
    assert property (@(posedge clk) disable iff (rst) walk_ack && walk_req |=> walk_ack)
        else $error("walk_ack fell while walk_req was still high");

    for (genvar i = 0; i < `MMU_PORTS; i++) begin : g_port
        for (genvar j = i + 1; j < `MMU_PORTS; j++) begin : g_pair
            assert property (@(posedge clk) disable iff (rst)
                !(resp_valid[i] && resp_valid[j] && resp[i].id == resp[j].id))
                else $error("ports %0d and %0d answered the same ID", i, j);
        end
    end

endmodule

bind mmu_top mmu_assert mmu_assert_inst (
    .clk        (clk),
    .rst        (rst),
    .walk_req   (walk_req),
    .walk_ack   (walk_ack),
    .resp       (resp),
    .resp_valid (resp_valid)
);

/* bench/mmu_tb.sv */
// MMU testbench with clock, reset, watchdog, directed tests, compare tasks and summary
`include "tlb_macros.svh"

module mmu_tb import tlb_pkg::*; ();

    localparam int SEL_W    = $clog2(`MMU_PORTS);
    localparam int PT_IDX_W = $clog2(`PT_DEPTH);
    localparam int N_TESTS  = 7;
    localparam int RESP_MAX = 64;
    localparam int WAIT_MAX = 1000; // cycles for any single wait
    localparam int LAT_HIT  = 1;
    localparam int LAT_MISS = 2;

    logic                  clk;
    logic                  rst;
    xlat_req_t             req;
    logic                  req_valid;
    logic                  req_ready;
    xlat_resp_t            resp [`MMU_PORTS];
    logic [`MMU_PORTS-1:0] resp_valid;
    logic                  flush_valid;
    logic [8:0]            flush_asid;
    logic [8:0]            flush_mask;
    logic                  pt_wr_valid;
    pt_write_t             pt_wr;

    pt_write_t  page_model [`PT_DEPTH]; // mirror of the page table writes
    logic       model_used [`PT_DEPTH] = '{default: 1'b0};
    xlat_resp_t got_resp [`MMU_PORTS][RESP_MAX];
    int         got_cyc [`MMU_PORTS][RESP_MAX];
    int         got_cnt [`MMU_PORTS] = '{default: 0};
    int         rd_ptr [`MMU_PORTS] = '{default: 0};
    int         cycle = 0;
    int         errors = 0;
    int         checks = 0;
    integer     seed = 78665;

    mmu_top mmu_top_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .resp        (resp),
        .resp_valid  (resp_valid),
        .flush_valid (flush_valid),
        .flush_asid  (flush_asid),
        .flush_mask  (flush_mask),
        .pt_wr_valid (pt_wr_valid),
        .pt_wr       (pt_wr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // responses have no ready, so every one is captured as it appears
    always @(negedge clk) begin
        for (int p = 0; p < `MMU_PORTS; p++) begin
            if (!rst && resp_valid[p] === 1'b1 && got_cnt[p] < RESP_MAX) begin
                got_resp[p][got_cnt[p]] = resp[p];
                got_cyc[p][got_cnt[p]]  = cycle;
                got_cnt[p]++;
            end
        end
    end

    initial begin
        repeat (N_TESTS * 2000) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", N_TESTS * 2000);
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [7:0] id_for(input int port, input int n);
        return 8'((port << (8 - SEL_W)) | n); // top bits select the slice
    endfunction

    function automatic int port_of(input logic [7:0] id);
        return int'(id[7 -: SEL_W]);
    endfunction

    function automatic xlat_req_t make_req(input logic [7:0] id, input logic [31:0] vaddr,
                                           input logic mode, input logic [8:0] asid);
        xlat_req_t r;
        r.id        = id;
        r.vaddr     = vaddr;
        r.satp.mode = mode;
        r.satp.asid = asid;
        return r;
    endfunction

    // expected answer from the mirrored table with a fault on tag mismatch or zero permission
    function automatic xlat_resp_t table_xlat(input xlat_req_t r);
        xlat_resp_t e;
        int         idx;
        e.id    = r.id;
        e.perm  = 8'hff;
        e.paddr = r.vaddr; // bare mode passes through
        if (r.satp.mode) begin
            idx = int'(r.vaddr[12 +: PT_IDX_W]);
            if (model_used[idx] && page_model[idx].tag.vpn == r.vaddr[31:12] &&
                page_model[idx].tag.asid == r.satp.asid && page_model[idx].data.perm != 8'h00) begin
                e.perm  = page_model[idx].data.perm;
                e.paddr = {page_model[idx].data.ppn, r.vaddr[11:0]};
            end else begin
                e.perm  = 8'h00;
                e.paddr = '0;
            end
        end
        return e;
    endfunction

    // paddr carries no meaning on a fault
    task automatic check_resp(input string name, input xlat_resp_t got, input xlat_resp_t exp);
        checks++;
        if (got.id !== exp.id || got.perm !== exp.perm ||
            (exp.perm != 8'h00 && got.paddr !== exp.paddr)) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic write_pt(input logic [19:0] vpn, input logic [8:0] asid,
                            input logic [19:0] ppn, input logic [7:0] perm);
        pt_write_t w;
        w.tag.vpn   = vpn;
        w.tag.asid  = asid;
        w.data.ppn  = ppn;
        w.data.perm = perm;
        @(posedge clk);
        #1;
        pt_wr       = w;
        pt_wr_valid = 1'b1;
        page_model[vpn[PT_IDX_W-1:0]] = w;
        model_used[vpn[PT_IDX_W-1:0]] = 1'b1;
        @(posedge clk);
        #1;
        pt_wr_valid = 1'b0;
    endtask

    task automatic flush(input logic [8:0] asid, input logic [8:0] mask);
        @(posedge clk);
        #1;
        flush_valid = 1'b1;
        flush_asid  = asid;
        flush_mask  = mask;
        @(posedge clk);
        #1;
        flush_valid = 1'b0;
    endtask

    // holds the request until req_ready was high at an edge
    task automatic send_req(input xlat_req_t r, output int acc_cyc);
        int   waited;
        logic ok;
        waited = 0;
        @(posedge clk);
        #1;
        req       = r;
        req_valid = 1'b1;
        do begin
            @(negedge clk);
            ok = req_ready;
            @(posedge clk);
            waited++;
        end while (ok !== 1'b1 && waited < WAIT_MAX);
        #1;
        req_valid = 1'b0;
        acc_cyc   = cycle; // count of the accepting edge
        if (ok !== 1'b1) begin
            errors++;
            $display("request id %h was not accepted within %0d cycles", r.id, WAIT_MAX);
        end
    endtask

    task automatic expect_resp(input xlat_resp_t exp, input int acc_cyc, input int lat_mode);
        int         port;
        int         waited;
        int         lat;
        xlat_resp_t got;
        port   = port_of(exp.id);
        waited = 0;
        while (rd_ptr[port] >= got_cnt[port] && waited < WAIT_MAX) begin
            @(posedge clk);
            waited++;
        end
        if (rd_ptr[port] >= got_cnt[port]) begin
            errors++;
            $display("no response for id %h on port %0d within %0d cycles", exp.id, port, WAIT_MAX);
        end else begin
            got = got_resp[port][rd_ptr[port]];
            lat = got_cyc[port][rd_ptr[port]] - acc_cyc;
            rd_ptr[port]++;
            check_resp($sformatf("resp[%0d]", port), got, exp);
            if (lat_mode == LAT_HIT) begin
                check_flag($sformatf("resp_valid[%0d] one cycle after accept", port),
                           lat == 1, 1'b1);
            end else if (lat_mode == LAT_MISS) begin
                check_flag($sformatf("resp_valid[%0d] later than a hit", port), lat > 1, 1'b1);
            end
        end
    endtask

    task automatic access(input xlat_req_t r, input xlat_resp_t exp, input int lat_mode);
        int acc;
        send_req(r, acc);
        expect_resp(exp, acc, lat_mode);
    endtask

    task automatic test_reset_state();
        check_flag("req_ready", req_ready, 1'b1);
        check_flag("resp_valid", |resp_valid, 1'b0);
    endtask

    task automatic test_bare_mode();
        xlat_req_t r;
        for (int p = 0; p < `MMU_PORTS; p++) begin
            r = make_req(id_for(p, 1), 32'($random(seed)), 1'b0, 9'h000);
            access(r, table_xlat(r), LAT_HIT);
        end
    endtask

    task automatic test_miss_then_hit();
        xlat_req_t  r;
        xlat_resp_t exp;
        write_pt(20'h12345, 9'h033, 20'h0abcd, 8'h0f);
        r   = make_req(id_for(0, 2), {20'h12345, 12'h678}, 1'b1, 9'h033);
        exp = table_xlat(r);
        access(r, exp, LAT_MISS);
        r.id   = id_for(0, 3);
        exp.id = r.id;
        access(r, exp, LAT_HIT);
    endtask

    task automatic test_page_fault();
        xlat_req_t r;
        r = make_req(id_for(2, 4), {20'h0040a, 12'h010}, 1'b1, 9'h044);
        access(r, table_xlat(r), LAT_MISS); // unmapped
        write_pt(20'h0040a, 9'h044, 20'h5a5a5, 8'h07);
        r.id = id_for(2, 5);
        access(r, table_xlat(r), LAT_MISS); // walks again
    endtask

    task automatic test_flush_asid();
        xlat_req_t  ra;
        xlat_req_t  rb;
        xlat_resp_t old;
        xlat_resp_t other;
        write_pt(20'h2000c, 9'h011, 20'h11111, 8'h03);
        ra  = make_req(id_for(1, 6), {20'h2000c, 12'h004}, 1'b1, 9'h011);
        old = table_xlat(ra);
        access(ra, old, LAT_MISS);
        write_pt(20'h2000c, 9'h011, 20'h22222, 8'h03); // remap behind the TLB
        ra.id  = id_for(1, 7);
        old.id = ra.id;
        access(ra, old, LAT_HIT);
        write_pt(20'h2000c, 9'h022, 20'h33333, 8'h05); // same VPN under another ASID
        rb    = make_req(id_for(1, 8), {20'h2000c, 12'h008}, 1'b1, 9'h022);
        other = table_xlat(rb);
        access(rb, other, LAT_MISS);
        flush(9'h011, 9'h000);
        write_pt(20'h2000c, 9'h011, 20'h22222, 8'h03);
        ra.id = id_for(1, 9);
        access(ra, table_xlat(ra), LAT_MISS);
        rb.id    = id_for(1, 10);
        other.id = rb.id;
        access(rb, other, LAT_HIT);
    endtask

    task automatic test_contention();
        xlat_req_t   rq [2*`MMU_PORTS];
        xlat_resp_t  ex [2*`MMU_PORTS];
        int          acc [2*`MMU_PORTS];
        logic [19:0] vpn;
        logic [8:0]  asid;
        for (int k = 0; k < 2 * `MMU_PORTS; k++) begin
            vpn  = 20'($random(seed));
            vpn[PT_IDX_W-1:0] = PT_IDX_W'(6'h30 + k); // own table slot per page
            asid = 9'($random(seed));
            write_pt(vpn, asid, 20'($random(seed)), 8'($random(seed)) | 8'h01);
            rq[k] = make_req(id_for(k % `MMU_PORTS, 11 + k), {vpn, 12'($random(seed))},
                             1'b1, asid);
            ex[k] = table_xlat(rq[k]);
        end
        for (int k = 0; k < 2 * `MMU_PORTS; k++) begin
            send_req(rq[k], acc[k]); // second round stalls on busy slices
        end
        for (int k = 0; k < 2 * `MMU_PORTS; k++) begin
            expect_resp(ex[k], acc[k], LAT_MISS);
        end
    endtask

    task automatic test_replacement();
        xlat_req_t   r;
        logic [19:0] vpn;
        for (int k = 0; k < 3; k++) begin
            vpn = 20'h0a007 + 20'h01010 * 20'(k); // one TLB set but distinct table slots
            write_pt(vpn, 9'h066, 20'h70000 + 20'(k), 8'h0b);
        end
        for (int k = 0; k < 4; k++) begin
            vpn = 20'h0a007 + 20'h01010 * 20'(k % 3);
            r   = make_req(id_for(3, 20 + k), {vpn, 12'h100}, 1'b1, 9'h066);
            access(r, table_xlat(r), LAT_MISS); // last one was evicted
        end
    endtask

    task automatic check_leftovers();
        for (int p = 0; p < `MMU_PORTS; p++) begin
            if (got_cnt[p] != rd_ptr[p]) begin
                errors++;
                $display("port %0d gave %0d responses that no request was waiting for",
                         p, got_cnt[p] - rd_ptr[p]);
            end
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    initial begin
        int e0;
        rst         = 1'b1;
        req         = '0;
        req_valid   = 1'b0;
        flush_valid = 1'b0;
        flush_asid  = '0;
        flush_mask  = '0;
        pt_wr_valid = 1'b0;
        pt_wr       = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        e0 = errors;
        test_reset_state();
        report_test("reset_state", e0);
        e0 = errors;
        test_bare_mode();
        report_test("bare_mode", e0);
        e0 = errors;
        test_miss_then_hit();
        report_test("miss_then_hit", e0);
        e0 = errors;
        test_page_fault();
        report_test("page_fault", e0);
        e0 = errors;
        test_flush_asid();
        report_test("flush_asid", e0);
        e0 = errors;
        test_contention();
        report_test("contention", e0);
        e0 = errors;
        test_replacement();
        report_test("replacement", e0);

        repeat (20) @(posedge clk); // let stray responses show up
        check_leftovers();
        $display("summary: %0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hdl/tlb_pkg.sv
hdl/req_steer.sv
hdl/tlb_slice.sv
hdl/miss_arbiter.sv
hdl/page_walker.sv
hdl/mmu_top.sv
bench/mmu_assert.sv
bench/mmu_tb.sv

/* Bender.yml */
package:
  name: mmu_tlb

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/tlb_pkg.sv
      - hdl/req_steer.sv
      - hdl/tlb_slice.sv
      - hdl/miss_arbiter.sv
      - hdl/page_walker.sv
      - hdl/mmu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/mmu_assert.sv
      - bench/mmu_tb.sv
